// File: logic/udma_pkg.sv
/*
 * Types and encodings shared by the uDMA stream channel.
 * Sizes count bytes but only whole words move; the low two bits are ignored.
 */
package udma_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    typedef logic [31:0] word_t;        // Stream and memory data word
    typedef logic [15:0] trans_size_t;  // Byte count
    typedef logic [4:0]  cfg_addr_t;    // Register index

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////
    typedef enum cfg_addr_t {
        REG_RX_SADDR = 5'd0,
        REG_RX_SIZE  = 5'd1,
        REG_RX_CFG   = 5'd2,
        REG_TX_SADDR = 5'd3,
        REG_TX_SIZE  = 5'd4,
        REG_TX_CFG   = 5'd5,
        REG_STATUS   = 5'd9
    } cfg_reg_e;

    localparam int CFG_EN_BIT  = 4;  // Start bit in a CFG write
    localparam int CFG_CLR_BIT = 5;  // Abort bit, wins over start

    // Per-direction transfer state
    typedef enum logic {
        CH_IDLE,
        CH_RUN
    } chan_state_e;

endpackage

// File: logic/chan_cfg_if.sv
/*
 * Settings and status of one transfer direction.
 * start and clear are single-cycle pulses and never high together.
 */
`timescale 1ns/1ps

interface chan_cfg_if #(
    parameter int L2AddrWidth = 12
);

    logic [L2AddrWidth-1:0] start_addr;  // First byte address
    udma_pkg::trans_size_t  size;        // Programmed size in bytes
    logic                   start;
    logic                   clear;
    logic                   busy;
    udma_pkg::trans_size_t  bytes_left;

    modport regs (
        output start_addr, size, start, clear,
        input  busy, bytes_left
    );

    modport ctrl (
        input  start_addr, size, start, clear,
        output busy, bytes_left
    );

endinterface

// File: logic/l2_if.sv
/*
 * Local memory ports, one word write and one word read per cycle.
 * Read data comes back one cycle after rd_en, outside this bundle.
 */
`timescale 1ns/1ps

interface l2_if #(
    parameter int L2AddrWidth = 12
);

    logic                   wr_en;
    logic [L2AddrWidth-1:0] wr_addr;
    udma_pkg::word_t        wr_data;
    logic                   rd_en;
    logic [L2AddrWidth-1:0] rd_addr;

    modport ctrl (
        output wr_en, wr_addr, wr_data, rd_en, rd_addr
    );

    modport mem (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr
    );

endinterface

// File: logic/cfg_regs.sv
/*
 * Register bank on a plain strobe bus with no handshake.
 * Writes land on the next edge; read data follows the strobe by one cycle
 * and holds until the next read. CFG registers read back as zero.
 */
`timescale 1ns/1ps

module cfg_regs #(
    parameter int L2AddrWidth = 12
) (
    input  logic                sys_clk,
    input  logic                rst_n,
    input  logic                cfg_valid_i,
    input  logic                cfg_rwn_i,
    input  udma_pkg::cfg_addr_t cfg_addr_i,
    input  udma_pkg::word_t     cfg_data_i,
    output udma_pkg::word_t     cfg_data_o,
    chan_cfg_if.regs            rx_cfg,
    chan_cfg_if.regs            tx_cfg
);

    logic            wr;
    logic            cfg_en;
    logic            cfg_clr;
    udma_pkg::word_t status;

    assign wr      = cfg_valid_i && !cfg_rwn_i;
    assign cfg_en  = cfg_data_i[udma_pkg::CFG_EN_BIT] && !cfg_data_i[udma_pkg::CFG_CLR_BIT];
    assign cfg_clr = cfg_data_i[udma_pkg::CFG_CLR_BIT];

    assign status = {tx_cfg.bytes_left, 14'd0, tx_cfg.busy, rx_cfg.busy};

    ////////////////////////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_cfg.start_addr <= '0;
            rx_cfg.size       <= '0;
            tx_cfg.start_addr <= '0;
            tx_cfg.size       <= '0;
            rx_cfg.start      <= 1'b0;
            rx_cfg.clear      <= 1'b0;
            tx_cfg.start      <= 1'b0;
            tx_cfg.clear      <= 1'b0;
        end else begin
            rx_cfg.start <= wr && (cfg_addr_i == udma_pkg::REG_RX_CFG) && cfg_en;
            rx_cfg.clear <= wr && (cfg_addr_i == udma_pkg::REG_RX_CFG) && cfg_clr;
            tx_cfg.start <= wr && (cfg_addr_i == udma_pkg::REG_TX_CFG) && cfg_en;
            tx_cfg.clear <= wr && (cfg_addr_i == udma_pkg::REG_TX_CFG) && cfg_clr;
            if (wr) begin
                case (cfg_addr_i)
                    udma_pkg::REG_RX_SADDR: rx_cfg.start_addr <= cfg_data_i[L2AddrWidth-1:0];
                    udma_pkg::REG_RX_SIZE:  rx_cfg.size       <= cfg_data_i[15:0];
                    udma_pkg::REG_TX_SADDR: tx_cfg.start_addr <= cfg_data_i[L2AddrWidth-1:0];
                    udma_pkg::REG_TX_SIZE:  tx_cfg.size       <= cfg_data_i[15:0];
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read data
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_data_o <= '0;
        end else if (cfg_valid_i && cfg_rwn_i) begin
            case (cfg_addr_i)
                udma_pkg::REG_RX_SADDR: cfg_data_o <= udma_pkg::word_t'(rx_cfg.start_addr);
                udma_pkg::REG_RX_SIZE:  cfg_data_o <= udma_pkg::word_t'(rx_cfg.size);
                udma_pkg::REG_TX_SADDR: cfg_data_o <= udma_pkg::word_t'(tx_cfg.start_addr);
                udma_pkg::REG_TX_SIZE:  cfg_data_o <= udma_pkg::word_t'(tx_cfg.size);
                udma_pkg::REG_STATUS:   cfg_data_o <= status;
                default:                cfg_data_o <= '0;  // CFG and unmapped
            endcase
        end
    end

endmodule

// File: logic/chan_ctrl.sv
/*
 * RX and TX transfer control. A start is taken only while idle and with
 * at least one whole word; a clear drops the direction to idle without eot.
 * TX reads run ahead of the output by at most two words.
 */
`timescale 1ns/1ps

module chan_ctrl #(
    parameter int L2AddrWidth = 12
) (
    input  logic            sys_clk,
    input  logic            rst_n,
    chan_cfg_if.ctrl        rx_cfg,
    chan_cfg_if.ctrl        tx_cfg,
    input  logic            rx_valid_i,
    input  udma_pkg::word_t rx_data_i,
    output logic            rx_ready_o,
    l2_if.ctrl              mem,
    input  logic            tx_room_i,
    input  logic            tx_accept_i,
    input  logic            tx_drained_i,
    output logic            tx_flush_o,
    output logic            evt_eot_o
);

    localparam udma_pkg::trans_size_t WordBytes = 16'd4;

    udma_pkg::chan_state_e  rx_state_q;
    logic [L2AddrWidth-1:0] rx_addr_q;
    udma_pkg::trans_size_t  rx_left_q;
    logic                   rx_fire;
    logic                   rx_last;

    udma_pkg::chan_state_e  tx_state_q;
    logic [L2AddrWidth-1:0] tx_addr_q;    // Next read address
    udma_pkg::trans_size_t  tx_issue_q;   // Bytes not yet read
    udma_pkg::trans_size_t  tx_left_q;    // Bytes not yet accepted
    logic                   tx_last;

    ////////////////////////////////////////////////////////////
    // RX: stream into memory
    ////////////////////////////////////////////////////////////
    assign rx_ready_o = (rx_state_q == udma_pkg::CH_RUN);
    assign rx_fire    = rx_valid_i && rx_ready_o;
    assign rx_last    = rx_fire && (rx_left_q == WordBytes);

    assign mem.wr_en   = rx_fire;            // Written on the accepting edge
    assign mem.wr_addr = rx_addr_q;
    assign mem.wr_data = rx_data_i;

    assign rx_cfg.busy       = rx_ready_o;
    assign rx_cfg.bytes_left = rx_left_q;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_state_q <= udma_pkg::CH_IDLE;
            rx_addr_q  <= '0;
            rx_left_q  <= '0;
        end else if (rx_cfg.clear) begin
            rx_state_q <= udma_pkg::CH_IDLE;
            rx_left_q  <= '0;
        end else begin
            case (rx_state_q)
                udma_pkg::CH_IDLE: begin
                    if (rx_cfg.start && (rx_cfg.size[15:2] != '0)) begin
                        rx_state_q <= udma_pkg::CH_RUN;
                        rx_addr_q  <= rx_cfg.start_addr;
                        rx_left_q  <= {rx_cfg.size[15:2], 2'b00};  // Whole words only
                    end
                end
                udma_pkg::CH_RUN: begin
                    if (rx_fire) begin
                        rx_addr_q <= rx_addr_q + L2AddrWidth'(4);
                        rx_left_q <= rx_left_q - WordBytes;
                    end
                    if (rx_last) begin
                        rx_state_q <= udma_pkg::CH_IDLE;
                    end
                end
                default: rx_state_q <= udma_pkg::CH_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // TX: memory reads toward the streamer
    ////////////////////////////////////////////////////////////
    assign mem.rd_en   = (tx_state_q == udma_pkg::CH_RUN) && (tx_issue_q != '0) &&
                         tx_room_i && !tx_cfg.clear;
    assign mem.rd_addr = tx_addr_q;
    assign tx_flush_o  = tx_cfg.clear;   // Drop held and in-flight words
    assign tx_last     = tx_accept_i && (tx_state_q == udma_pkg::CH_RUN) &&
                         (tx_left_q == WordBytes);

    assign tx_cfg.busy       = (tx_state_q == udma_pkg::CH_RUN);
    assign tx_cfg.bytes_left = tx_left_q;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_state_q <= udma_pkg::CH_IDLE;
            tx_addr_q  <= '0;
            tx_issue_q <= '0;
            tx_left_q  <= '0;
        end else if (tx_cfg.clear) begin
            tx_state_q <= udma_pkg::CH_IDLE;
            tx_issue_q <= '0;
            tx_left_q  <= '0;
        end else begin
            case (tx_state_q)
                udma_pkg::CH_IDLE: begin
                    if (tx_cfg.start && tx_drained_i && (tx_cfg.size[15:2] != '0)) begin
                        tx_state_q <= udma_pkg::CH_RUN;
                        tx_addr_q  <= tx_cfg.start_addr;
                        tx_issue_q <= {tx_cfg.size[15:2], 2'b00};
                        tx_left_q  <= {tx_cfg.size[15:2], 2'b00};
                    end
                end
                udma_pkg::CH_RUN: begin
                    if (mem.rd_en) begin
                        tx_addr_q  <= tx_addr_q + L2AddrWidth'(4);
                        tx_issue_q <= tx_issue_q - WordBytes;
                    end
                    if (tx_accept_i) begin
                        tx_left_q <= tx_left_q - WordBytes;
                    end
                    if (tx_last) begin
                        tx_state_q <= udma_pkg::CH_IDLE;
                    end
                end
                default: tx_state_q <= udma_pkg::CH_IDLE;
            endcase
        end
    end

    // One pulse covers both directions finishing together
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            evt_eot_o <= 1'b0;
        end else begin
            evt_eot_o <= (rx_last && !rx_cfg.clear) || (tx_last && !tx_cfg.clear);
        end
    end

    // A read goes out only with at most one word read but not yet accepted
    a_tx_read_bound: assert property (
        @(posedge sys_clk) disable iff (!rst_n)
        mem.rd_en |-> (tx_left_q - tx_issue_q) <= WordBytes
    );

endmodule

// File: logic/l2_mem.sv
/*
 * Byte array standing in for L2, words stored little-endian.
 * Addresses need not be word aligned and wrap at the top of the array.
 * No reset, contents are undefined until written.
 */
`timescale 1ns/1ps

module l2_mem #(
    parameter int L2AddrWidth = 12
) (
    input  logic            sys_clk,
    l2_if.mem               mem,
    output udma_pkg::word_t rd_data_o
);

    logic [7:0] mem_q [2**L2AddrWidth];

    // Write port
    always_ff @(posedge sys_clk) begin
        if (mem.wr_en) begin
            for (int i = 0; i < 4; i++) begin
                mem_q[mem.wr_addr + L2AddrWidth'(i)] <= mem.wr_data[8*i +: 8];  // LSB first
            end
        end
    end

    // Synchronous read, data valid the cycle after rd_en
    always_ff @(posedge sys_clk) begin
        if (mem.rd_en) begin
            for (int i = 0; i < 4; i++) begin
                rd_data_o[8*i +: 8] <= mem_q[mem.rd_addr + L2AddrWidth'(i)];
            end
        end
    end

endmodule

// File: logic/tx_streamer.sv
/*
 * Two-entry output buffer behind the synchronous memory read.
 * room_o counts a read in flight as taken, so in-flight plus held never
 * exceeds two. A flush drops everything, including a read in flight.
 */
`timescale 1ns/1ps

module tx_streamer (
    input  logic            sys_clk,
    input  logic            rst_n,
    input  logic            fetch_i,
    input  udma_pkg::word_t rd_data_i,
    input  logic            flush_i,
    input  logic            tx_ready_i,
    output logic            tx_valid_o,
    output udma_pkg::word_t tx_data_o,
    output logic            room_o,
    output logic            accept_o,
    output logic            drained_o
);

    udma_pkg::word_t buf_q [2];
    logic [1:0]      count_q;     // Held words
    logic            inflight_q;  // Read data arrives this cycle
    logic            wr_ptr_q;
    logic            rd_ptr_q;

    assign tx_valid_o = (count_q != 2'd0);
    assign tx_data_o  = buf_q[rd_ptr_q];
    assign accept_o   = tx_valid_o && tx_ready_i;
    assign room_o     = (2'(inflight_q) + count_q) < 2'd2;
    assign drained_o  = (count_q == 2'd0) && !inflight_q;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q    <= 2'd0;
            inflight_q <= 1'b0;
            wr_ptr_q   <= 1'b0;
            rd_ptr_q   <= 1'b0;
        end else if (flush_i) begin
            count_q    <= 2'd0;
            inflight_q <= 1'b0;
            wr_ptr_q   <= 1'b0;
            rd_ptr_q   <= 1'b0;
        end else begin
            inflight_q <= fetch_i;
            count_q    <= count_q + 2'(inflight_q) - 2'(accept_o);
            if (inflight_q) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (accept_o) begin
                rd_ptr_q <= !rd_ptr_q;
            end
        end
    end

    // Arriving word never lands on the presented entry
    always_ff @(posedge sys_clk) begin
        if (inflight_q) begin
            buf_q[wr_ptr_q] <= rd_data_i;
        end
    end

    a_tx_hold: assert property (
        @(posedge sys_clk) disable iff (!rst_n || flush_i)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o)
    );

endmodule

// File: logic/udma_channel.sv
/*
 * Single uDMA stream channel with its own local memory.
 * L2AddrWidth sets the memory size in bytes as a power of two, 4 to 16.
 */
`timescale 1ns/1ps

module udma_channel #(
    parameter int L2AddrWidth = 12
) (
    input  logic                sys_clk,
    input  logic                rst_n,
    input  logic                cfg_valid_i,
    input  logic                cfg_rwn_i,   // 1 is read
    input  udma_pkg::cfg_addr_t cfg_addr_i,
    input  udma_pkg::word_t     cfg_data_i,
    output udma_pkg::word_t     cfg_data_o,
    input  udma_pkg::word_t     rx_data_i,
    input  logic                rx_valid_i,
    output logic                rx_ready_o,
    output udma_pkg::word_t     tx_data_o,
    output logic                tx_valid_o,
    input  logic                tx_ready_i,
    output logic                evt_eot_o
);

    logic            tx_room;
    logic            tx_accept;
    logic            tx_drained;
    logic            tx_flush;
    udma_pkg::word_t l2_rd_data;

    chan_cfg_if #(.L2AddrWidth(L2AddrWidth)) rx_cfg ();
    chan_cfg_if #(.L2AddrWidth(L2AddrWidth)) tx_cfg ();
    l2_if       #(.L2AddrWidth(L2AddrWidth)) l2_bus ();

    cfg_regs #(
        .L2AddrWidth (L2AddrWidth)
    ) u_cfg_regs (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .cfg_valid_i (cfg_valid_i),
        .cfg_rwn_i   (cfg_rwn_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_data_i  (cfg_data_i),
        .cfg_data_o  (cfg_data_o),
        .rx_cfg      (rx_cfg),
        .tx_cfg      (tx_cfg)
    );

    chan_ctrl #(
        .L2AddrWidth (L2AddrWidth)
    ) u_chan_ctrl (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .rx_cfg       (rx_cfg),
        .tx_cfg       (tx_cfg),
        .rx_valid_i   (rx_valid_i),
        .rx_data_i    (rx_data_i),
        .rx_ready_o   (rx_ready_o),
        .mem          (l2_bus),
        .tx_room_i    (tx_room),
        .tx_accept_i  (tx_accept),
        .tx_drained_i (tx_drained),
        .tx_flush_o   (tx_flush),
        .evt_eot_o    (evt_eot_o)
    );

    l2_mem #(
        .L2AddrWidth (L2AddrWidth)
    ) u_l2_mem (
        .sys_clk   (sys_clk),
        .mem       (l2_bus),
        .rd_data_o (l2_rd_data)
    );

    tx_streamer u_tx_streamer (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .fetch_i    (l2_bus.rd_en),
        .rd_data_i  (l2_rd_data),
        .flush_i    (tx_flush),
        .tx_ready_i (tx_ready_i),
        .tx_valid_o (tx_valid_o),
        .tx_data_o  (tx_data_o),
        .room_o     (tx_room),
        .accept_o   (tx_accept),
        .drained_o  (tx_drained)
    );

endmodule

// File: tb/tb_udma_channel.sv
/*
 * Testbench for the single uDMA stream channel.
 * Concurrent assertions do the checking; the tests only steer the DUT into them.
 * TX reads back the words that the RX test left in memory, so test order matters.
 */
`timescale 1ns/1ps

module tb_udma_channel;

    localparam int L2AW       = 12;
    localparam int N_WORDS    = 16;
    localparam int LONG_WORDS = 256;
    localparam int T_REGS     = 80;                // Test lengths in cycles
    localparam int T_RX       = N_WORDS * 8 + 40;
    localparam int T_TX       = N_WORDS * 4 + 50;
    localparam int T_BP       = N_WORDS * 10 + 60;
    localparam int T_ABORT    = 120;
    localparam int T_ZERO     = 60;
    localparam int WATCHDOG   = T_REGS + T_RX + T_TX + T_BP + T_ABORT + T_ZERO + 200;

    logic                sys_clk = 1'b0;
    logic                rst_n;
    logic                cfg_valid_i;
    logic                cfg_rwn_i;
    udma_pkg::cfg_addr_t cfg_addr_i;
    udma_pkg::word_t     cfg_data_i;
    udma_pkg::word_t     cfg_data_o;
    udma_pkg::word_t     rx_data_i;
    logic                rx_valid_i;
    logic                rx_ready_o;
    udma_pkg::word_t     tx_data_o;
    logic                tx_valid_o;
    logic                tx_ready_i;
    logic                evt_eot_o;

    udma_pkg::word_t sb [$];          // Words accepted by RX, in order
    udma_pkg::word_t exp_tx;
    udma_pkg::word_t rd_exp;
    udma_pkg::word_t rd_mask;
    udma_pkg::word_t rd_exp_q;
    udma_pkg::word_t rd_mask_q;
    logic            rd_left;         // Expect STATUS bytes left from handshakes
    logic            rd_chk_q;
    logic            cnt_clr;
    logic            rx_window;       // RX may be busy
    logic            tx_chk_en;
    logic            abort_win;
    logic            eot_ok;
    int              rx_acc;
    int              hs_cnt;
    int              eot_cnt;
    int              n_words;
    int              tx_size;
    int              err_cnt;
    int              n_tests;
    int              n_failed;
    string           cur_test;

    udma_channel #(
        .L2AddrWidth (L2AW)
    ) dut (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .cfg_valid_i (cfg_valid_i),
        .cfg_rwn_i   (cfg_rwn_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_data_i  (cfg_data_i),
        .cfg_data_o  (cfg_data_o),
        .rx_data_i   (rx_data_i),
        .rx_valid_i  (rx_valid_i),
        .rx_ready_o  (rx_ready_o),
        .tx_data_o   (tx_data_o),
        .tx_valid_o  (tx_valid_o),
        .tx_ready_i  (tx_ready_i),
        .evt_eot_o   (evt_eot_o)
    );

    always #20 sys_clk = !sys_clk;     // 40 ns period

    always @* exp_tx = sb[hs_cnt];

    ////////////////////////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////////////////////////
    always @(posedge sys_clk) begin
        if (cnt_clr) begin
            rx_acc  <= 0;
            hs_cnt  <= 0;
            eot_cnt <= 0;
        end else begin
            if (rx_valid_i && rx_ready_o) begin
                sb.push_back(rx_data_i);
                rx_acc <= rx_acc + 1;
            end
            if (tx_valid_o && tx_ready_i) begin
                hs_cnt <= hs_cnt + 1;
            end
            if (evt_eot_o) begin
                eot_cnt <= eot_cnt + 1;
            end
        end
        rd_chk_q <= cfg_valid_i && cfg_rwn_i;
        if (cfg_valid_i && cfg_rwn_i) begin
            rd_mask_q <= rd_mask;
            rd_exp_q  <= rd_left ? {16'(tx_size - 4 * hs_cnt), 16'h0} : rd_exp;
        end
    end

    a_readback: assert property (@(posedge sys_clk) disable iff (!rst_n)
        rd_chk_q |-> ((cfg_data_o ^ rd_exp_q) & rd_mask_q) == '0)
    else begin
        err_cnt++;
        $display("Mismatch %s: expected %h actual %h", cur_test,
                 rd_exp_q & rd_mask_q, cfg_data_o & rd_mask_q);
    end

    a_rx_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !rx_window |-> !rx_ready_o)
    else begin
        err_cnt++;
        $display("%s: rx_ready_o high with no RX transfer active", cur_test);
    end

    a_rx_count: assert property (@(posedge sys_clk) disable iff (!rst_n)
        rx_valid_i && rx_ready_o |-> rx_acc < n_words)
    else begin
        err_cnt++;
        $display("%s: RX accepted more words than programmed", cur_test);
    end

    a_rx_end: assert property (@(posedge sys_clk) disable iff (!rst_n)
        rx_valid_i && rx_ready_o && rx_acc == n_words - 1 |=> evt_eot_o && !rx_ready_o)
    else begin
        err_cnt++;
        $display("%s: no eot or RX still ready after the last word", cur_test);
    end

    a_tx_data: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_chk_en && tx_valid_o && tx_ready_i |-> tx_data_o == exp_tx)
    else begin
        err_cnt++;
        $display("Mismatch %s: expected %h actual %h", cur_test, exp_tx, tx_data_o);
    end

    a_tx_count: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_chk_en && tx_valid_o && tx_ready_i |-> hs_cnt < n_words)
    else begin
        err_cnt++;
        $display("%s: TX sent more words than programmed", cur_test);
    end

    a_tx_end: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_chk_en && tx_valid_o && tx_ready_i && hs_cnt == n_words - 1 |=> evt_eot_o)
    else begin
        err_cnt++;
        $display("%s: no eot after the last TX handshake", cur_test);
    end

    a_tx_stable: assert property (@(posedge sys_clk) disable iff (!rst_n || abort_win)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o))
    else begin
        err_cnt++;
        $display("%s: tx_data_o changed or dropped under back-pressure", cur_test);
    end

    a_eot_ok: assert property (@(posedge sys_clk) disable iff (!rst_n)
        evt_eot_o |-> eot_ok)
    else begin
        err_cnt++;
        $display("%s: unexpected end-of-transfer event", cur_test);
    end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sys_clk);
        #2;
    endtask

    task automatic cfg_write(input udma_pkg::cfg_addr_t addr, input udma_pkg::word_t data);
        @(posedge sys_clk);
        #2;
        cfg_valid_i = 1'b1;
        cfg_rwn_i   = 1'b0;
        cfg_addr_i  = addr;
        cfg_data_i  = data;
        @(posedge sys_clk);
        #2;
        cfg_valid_i = 1'b0;
    endtask

    // The check itself sits in a_readback, one cycle after the strobe
    task automatic cfg_read(input udma_pkg::cfg_addr_t addr, input udma_pkg::word_t exp,
                            input udma_pkg::word_t mask, input logic left);
        @(posedge sys_clk);
        #2;
        rd_exp      = exp;
        rd_mask     = mask;
        rd_left     = left;
        cfg_valid_i = 1'b1;
        cfg_rwn_i   = 1'b1;
        cfg_addr_i  = addr;
        @(posedge sys_clk);
        #2;
        cfg_valid_i = 1'b0;
        rd_left     = 1'b0;
    endtask

    task automatic clear_counts();
        @(posedge sys_clk);
        #2;
        cnt_clr = 1'b1;
        @(posedge sys_clk);
        #2;
        cnt_clr = 1'b0;
    endtask

    task automatic check_eot_count(input int exp);
        assert (eot_cnt == exp) else begin
            err_cnt++;
            $display("Mismatch %s: expected %0d actual %0d eot pulses", cur_test, exp, eot_cnt);
        end
    endtask

    task automatic send_rx(input int limit);
        int cyc;
        cyc = 0;
        while (rx_acc < n_words && cyc < limit) begin
            @(posedge sys_clk);
            #2;
            rx_valid_i = ($urandom % 4) != 0;
            rx_data_i  = $urandom;
            cyc++;
        end
        rx_valid_i = 1'b1;          // Words past the end must be refused
        rx_data_i  = $urandom;
        wait_cycles(2);
        rx_valid_i = 1'b0;
        if (rx_acc < n_words) begin
            err_cnt++;
            $display("%s: timed out waiting for RX words", cur_test);
        end
    endtask

    // Runs the TX handshakes until eot shows up
    task automatic run_tx(input logic rand_ready, input int limit);
        int   cyc;
        logic done;
        cyc  = 0;
        done = 1'b0;
        while (!done && cyc < limit) begin
            @(posedge sys_clk);
            #2;
            done       = evt_eot_o;
            tx_ready_i = rand_ready ? 1'(($urandom % 2) != 0) : 1'b1;
            cyc++;
        end
        tx_ready_i = 1'b0;
        if (!done) begin
            err_cnt++;
            $display("%s: timed out waiting for end of TX", cur_test);
        end
    endtask

    task automatic start_tx(input int addr, input int size);
        tx_size = size & 32'hfffc;
        cfg_write(udma_pkg::REG_TX_SADDR, udma_pkg::word_t'(addr));
        cfg_write(udma_pkg::REG_TX_SIZE, udma_pkg::word_t'(size));
        cfg_write(udma_pkg::REG_TX_CFG, 32'h1 << udma_pkg::CFG_EN_BIT);
    endtask

    task automatic end_test(input int err_before);
        n_tests++;
        if (err_cnt == err_before) begin
            $display("%-14s passed", cur_test);
        end else begin
            n_failed++;
            $display("%-14s failed with %0d errors", cur_test, err_cnt - err_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    initial begin
        udma_pkg::word_t v [4];
        int              base;
        int              e0;
        int              cyc;
        void'($urandom(32'h06fc_cac8));
        {cfg_valid_i, cfg_rwn_i, rx_valid_i, tx_ready_i} = '0;
        cfg_addr_i = '0;
        cfg_data_i = '0;
        rx_data_i  = '0;
        {rd_exp, rd_mask, rd_left, cnt_clr} = '0;
        {rx_window, tx_chk_en, abort_win} = '0;
        eot_ok   = 1'b1;
        {err_cnt, n_tests, n_failed, n_words, tx_size} = '0;
        cur_test = "reset";
        rst_n    = 1'b0;
        repeat (5) @(posedge sys_clk);
        #2;
        rst_n = 1'b1;
        assert (!rx_ready_o && !tx_valid_o && !evt_eot_o && cfg_data_o == '0) else begin
            err_cnt++;
            $display("Outputs not idle after reset");
        end
        clear_counts();

        cur_test = "regs";
        e0 = err_cnt;
        foreach (v[i]) v[i] = $urandom;
        cfg_write(udma_pkg::REG_RX_SADDR, v[0]);
        cfg_write(udma_pkg::REG_RX_SIZE, v[1]);
        cfg_write(udma_pkg::REG_TX_SADDR, v[2]);
        cfg_write(udma_pkg::REG_TX_SIZE, v[3]);
        cfg_read(udma_pkg::REG_RX_SADDR, v[0] & ((32'h1 << L2AW) - 1), '1, 1'b0);
        cfg_read(udma_pkg::REG_RX_SIZE, v[1] & 32'hffff, '1, 1'b0);
        cfg_read(udma_pkg::REG_TX_SADDR, v[2] & ((32'h1 << L2AW) - 1), '1, 1'b0);
        cfg_read(udma_pkg::REG_TX_SIZE, v[3] & 32'hffff, '1, 1'b0);
        cfg_read(udma_pkg::REG_RX_CFG, '0, '1, 1'b0);
        cfg_read(udma_pkg::REG_STATUS, '0, '1, 1'b0);
        wait_cycles(2);
        end_test(e0);

        cur_test = "rx";
        e0 = err_cnt;
        base    = int'($urandom % 64) * 4;
        n_words = N_WORDS;
        clear_counts();
        rx_window = 1'b1;
        cfg_write(udma_pkg::REG_RX_SADDR, udma_pkg::word_t'(base));
        cfg_write(udma_pkg::REG_RX_SIZE, udma_pkg::word_t'(N_WORDS * 4 + int'($urandom % 4)));
        cfg_write(udma_pkg::REG_RX_CFG, 32'h1 << udma_pkg::CFG_EN_BIT);
        send_rx(N_WORDS * 8);
        wait_cycles(3);
        rx_window = 1'b0;
        check_eot_count(1);
        end_test(e0);

        cur_test = "tx";
        e0 = err_cnt;
        clear_counts();
        tx_chk_en = 1'b1;
        start_tx(base, N_WORDS * 4);
        run_tx(1'b0, N_WORDS * 4 + 20);
        wait_cycles(3);
        cfg_read(udma_pkg::REG_STATUS, '0, 32'h2, 1'b0);
        check_eot_count(1);
        end_test(e0);

        cur_test = "backpressure";
        e0 = err_cnt;
        clear_counts();
        start_tx(base, N_WORDS * 4);
        fork
            run_tx(1'b1, N_WORDS * 8 + 20);
            begin
                wait_cycles(N_WORDS);
                cfg_read(udma_pkg::REG_STATUS, '0, 32'hffff_0000, 1'b1);
            end
        join
        wait_cycles(3);
        check_eot_count(1);
        end_test(e0);

        cur_test = "abort";
        e0 = err_cnt;
        clear_counts();
        tx_chk_en = 1'b0;
        abort_win = 1'b1;
        eot_ok    = 1'b0;
        start_tx(0, LONG_WORDS * 4);
        cyc = 0;
        while (!tx_valid_o && cyc < 20) begin
            wait_cycles(1);
            tx_ready_i = 1'(($urandom % 2) != 0);
            cyc++;
        end
        if (!tx_valid_o) begin
            err_cnt++;
            $display("%s: TX never presented a word", cur_test);
        end
        wait_cycles(4);
        cfg_write(udma_pkg::REG_TX_CFG, 32'h1 << udma_pkg::CFG_CLR_BIT);
        wait_cycles(2);
        assert (!tx_valid_o) else begin
            err_cnt++;
            $display("%s: tx_valid_o still high after clear", cur_test);
        end
        cfg_read(udma_pkg::REG_STATUS, '0, '1, 1'b0);
        wait_cycles(10);
        tx_ready_i = 1'b0;
        abort_win  = 1'b0;
        check_eot_count(0);
        end_test(e0);

        cur_test = "zero_size";
        e0 = err_cnt;
        clear_counts();
        cfg_write(udma_pkg::REG_TX_SIZE, 32'd3);
        cfg_write(udma_pkg::REG_TX_CFG, 32'h1 << udma_pkg::CFG_EN_BIT);
        cfg_write(udma_pkg::REG_RX_SIZE, 32'd2);
        cfg_write(udma_pkg::REG_RX_CFG, 32'h1 << udma_pkg::CFG_EN_BIT);
        wait_cycles(4);
        cfg_read(udma_pkg::REG_STATUS, '0, '1, 1'b0);
        wait_cycles(4);
        check_eot_count(0);
        end_test(e0);

        $display("Tests %0d, failed %0d, errors %0d", n_tests, n_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge sys_clk);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: vlog.f
logic/udma_pkg.sv
logic/chan_cfg_if.sv
logic/l2_if.sv
logic/cfg_regs.sv
logic/chan_ctrl.sv
logic/l2_mem.sv
logic/tx_streamer.sv
logic/udma_channel.sv
tb/tb_udma_channel.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the uDMA channel testbench with Verilator.
# Exits nonzero unless the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert \
    --top-module tb_udma_channel -o sim_udma \
    -f vlog.f > build.log 2>&1 \
    && ./obj_dir/sim_udma > sim.log 2>&1 \
    || echo "Build or simulation returned an error, see build.log and sim.log"

grep -qx "=== PASS ===" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
